// File: compile.f
+incdir+.
floo_pkg.sv
floo_ingress_buffer.sv
floo_reduction_sync.sv
floo_reduction_arbiter.sv
floo_reduction_unit.sv
tb_floo_reduction_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the reduction unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_floo_reduction_unit \
  -f compile.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed the pass line
if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// File: tb_floo_reduction_unit.sv
`timescale 1ns/1ps

`include "floo_config.svh"

module tb_floo_reduction_unit;

  // ----------------------------------------
  // Run length and limits
  // ----------------------------------------

  localparam int NUM_GROUPS       = 200;
  localparam int CYCLES_PER_GROUP = 12;
  localparam int TIMEOUT_CYCLES   = NUM_GROUPS * CYCLES_PER_GROUP + 200;

  // DUT ports
  logic                                        clk_i;
  logic                                        rst_n_i;
  floo_pkg::route_mask_t                       valid_i;
  floo_pkg::route_mask_t                       ready_o;
  floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0] flit_i;
  logic                                        valid_o;
  logic                                        ready_i;
  floo_pkg::floo_flit_t                        flit_o;

  // Expected results in issue order and read back by output count
  floo_pkg::floo_flit_t exp_queue [0:NUM_GROUPS];
  int                   exp_cnt;
  int                   out_cnt;

  // Handshake history seen at the last rising edge
  floo_pkg::route_mask_t acc_q;
  logic                  free_q;
  logic                  started;

  int cycle_cnt;
  int value_errors;
  int protocol_errors;

  floo_reduction_unit UUT (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .flit_i  ( flit_i  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .flit_o  ( flit_o  )
  );

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  // Output count, accepted inputs and empty buffers as sampled before the edge
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_cnt <= 0;
      acc_q   <= '0;
      free_q  <= 1'b0;
    end else begin
      if (valid_o && ready_i) begin
        out_cnt <= out_cnt + 1;
      end
      acc_q  <= valid_i & ready_o;
      // All slots open and nothing offered means empty after this edge
      free_q <= (&ready_o) && (valid_i == '0);
    end
  end

  // Hard stop for a stuck run
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles with %0d of %0d groups out",
               cycle_cnt, out_cnt, NUM_GROUPS);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Idle port between reset and the first flit
  a_idle_after_reset: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !started |-> !valid_o && (ready_o == '1)
  ) else begin
    protocol_errors++;
    $display("Port not idle after reset at %0t", $time);
  end

  // Every output transfer needs a completed group waiting for it
  a_no_extra_output: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && ready_i |-> out_cnt < exp_cnt
  ) else begin
    protocol_errors++;
    $display("Output transfer at %0t with no completed group pending", $time);
  end

  // Head of the expected queue against the output
  a_out_value: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && ready_i && (out_cnt < exp_cnt) |-> flit_o == exp_queue[out_cnt]
  ) else begin
    value_errors++;
    $display("error at %0t: group %0d got flit %h, expected %h",
             $time, $sampled(out_cnt), $sampled(flit_o),
             exp_queue[$sampled(out_cnt)]);
  end

  // Stalled output keeps its flit
  a_out_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(flit_o)
  ) else begin
    value_errors++;
    $display("error at %0t: output flit dropped or changed while stalled", $time);
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  // Next falling edge with a fresh random ready that is low about 30% of cycles
  task automatic tick();
    @(negedge clk_i);
    ready_i = ($urandom_range(0, 9) >= 3);
  endtask

  function automatic logic [63:0] random_word64();
    return {$urandom(), $urandom()};
  endfunction

  // Result of one group from the reduction rules
  function automatic floo_pkg::floo_flit_t reduce_expected(
    input floo_pkg::floo_flit_t  flits [`FLOO_NUM_ROUTES],
    input floo_pkg::route_mask_t mask
  );
    floo_pkg::floo_flit_t res;
    int                   low;
    logic                 and_bit;
    logic                 hit;
    low = -1;
    for (int r = `FLOO_NUM_ROUTES - 1; r >= 0; r--) begin
      if (mask[r]) low = r;
    end
    res     = flits[low];
    and_bit = 1'b1;
    hit     = 1'b0;
    for (int r = 0; r < `FLOO_NUM_ROUTES; r++) begin
      if (mask[r]) begin
        and_bit = and_bit & flits[r].payload.w.data[0];
        // First slave error in route order
        if (!hit && flits[r].payload.b.resp == `FLOO_RESP_SLVERR) begin
          hit = 1'b1;
          if (res.hdr.collective_op == floo_pkg::CollectB) res = flits[r];
        end
      end
    end
    if (res.hdr.collective_op == floo_pkg::LsbAnd) res.payload.w.data[0] = and_bit;
    return res;
  endfunction

  // One group issued once the buffers are empty
  task automatic run_group();
    floo_pkg::floo_flit_t  flits [`FLOO_NUM_ROUTES];
    floo_pkg::route_mask_t mask;
    floo_pkg::route_mask_t pending;
    floo_pkg::floo_hdr_t   hdr;
    logic [63:0]           rnd;
    logic [1:0]            op_bits;
    int                    delay [`FLOO_NUM_ROUTES];
    int                    cyc;
    int                    pick;
    do tick(); while (!free_q);
    rnd     = random_word64();
    mask    = rnd[`FLOO_NUM_ROUTES-1:0];
    // Empty mask is not a group
    if (mask == '0) mask[rnd[`FLOO_NUM_ROUTES+1:`FLOO_NUM_ROUTES]] = 1'b1;
    pick    = $urandom_range(0, 2);
    op_bits = pick[1:0];
    hdr.collective_op = floo_pkg::collect_op_e'(op_bits);
    hdr.mask          = mask;
    hdr.tag           = rnd[`FLOO_TAG_WIDTH+15:16];
    for (int r = 0; r < `FLOO_NUM_ROUTES; r++) begin
      rnd            = random_word64();
      flits[r].hdr     = hdr;
      flits[r].payload = rnd[$bits(floo_pkg::floo_payload_u)-1:0];
      // Slave errors on about half of the B responses
      if (rnd[63]) begin
        flits[r].payload.b.resp = `FLOO_RESP_SLVERR;
      end else if (flits[r].payload.b.resp == `FLOO_RESP_SLVERR) begin
        flits[r].payload.b.resp = 2'd0;
      end
      delay[r] = $urandom_range(0, 3);
    end
    started = 1'b1;
    pending = mask;
    cyc     = 0;
    while (pending != '0) begin
      for (int r = 0; r < `FLOO_NUM_ROUTES; r++) begin
        if (pending[r] && cyc >= delay[r]) begin
          valid_i[r] = 1'b1;
          flit_i[r]  = flits[r];
        end
      end
      tick();
      pending = pending & ~acc_q;
      valid_i = valid_i & ~acc_q;
      cyc++;
    end
    // Pushed only once complete so an early output shows up as extra
    exp_queue[exp_cnt] = reduce_expected(flits, mask);
    exp_cnt++;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    void'($urandom(71689));
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    valid_i         = '0;
    flit_i          = '0;
    ready_i         = 1'b0;
    started         = 1'b0;
    exp_cnt         = 0;
    cycle_cnt       = 0;
    value_errors    = 0;
    protocol_errors = 0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (NUM_GROUPS) run_group();
    // Drain the last groups, then look for strays
    while (out_cnt < NUM_GROUPS) tick();
    repeat (6) tick();
    a_group_count: assert (out_cnt == NUM_GROUPS) else begin
      protocol_errors++;
      $display("Output count %0d does not match %0d groups", out_cnt, NUM_GROUPS);
    end
    $display("Summary: %0d groups, %0d outputs, %0d value errors, %0d protocol errors",
             exp_cnt, out_cnt, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: floo_reduction_unit.sv
`timescale 1ns/1ps

`include "floo_config.svh"

module floo_reduction_unit (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  // Input routes
  input  floo_pkg::route_mask_t                        valid_i,
  output floo_pkg::route_mask_t                        ready_o,
  input  floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0]  flit_i,
  // Reduced output
  output logic                                         valid_o,
  input  logic                                         ready_i,
  output floo_pkg::floo_flit_t                         flit_o
);

  // Buffered flits between ingress and reduction
  floo_pkg::route_mask_t                        buf_valid;
  floo_pkg::route_mask_t                        buf_ready;
  floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0]  buf_flit;

  // Per route group status
  floo_pkg::route_mask_t                        sync_valid;
  floo_pkg::route_mask_t [`FLOO_NUM_ROUTES-1:0] sync_mask;

  // ----------------------------------------
  // Ingress slots
  // ----------------------------------------

  floo_ingress_buffer i_ingress_buffer (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .valid_i     ( valid_i   ),
    .ready_o     ( ready_o   ),
    .flit_i      ( flit_i    ),
    .buf_valid_o ( buf_valid ),
    .buf_flit_o  ( buf_flit  ),
    .buf_ready_i ( buf_ready )
  );

  // One group check per route
  for (genvar i = 0; i < `FLOO_NUM_ROUTES; i++) begin : gen_reduction_sync
    floo_reduction_sync i_reduction_sync (
      .sel_i        ( floo_pkg::route_idx_t'(i) ),
      .buf_valid_i  ( buf_valid                 ),
      .buf_flit_i   ( buf_flit                  ),
      .sync_valid_o ( sync_valid[i]             ),
      .sync_mask_o  ( sync_mask[i]              )
    );
  end

  // ----------------------------------------
  // Reduction and output stage
  // ----------------------------------------

  floo_reduction_arbiter i_reduction_arbiter (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .sync_valid_i ( sync_valid ),
    .sync_mask_i  ( sync_mask  ),
    .buf_flit_i   ( buf_flit   ),
    .buf_ready_o  ( buf_ready  ),
    .valid_o      ( valid_o    ),
    .ready_i      ( ready_i    ),
    .flit_o       ( flit_o     )
  );

endmodule

// File: floo_reduction_arbiter.sv
`timescale 1ns/1ps

`include "floo_config.svh"

module floo_reduction_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  // Group status per route
  input  floo_pkg::route_mask_t                        sync_valid_i,
  input  floo_pkg::route_mask_t [`FLOO_NUM_ROUTES-1:0] sync_mask_i,
  input  floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0]  buf_flit_i,
  // Release of the participating slots
  output floo_pkg::route_mask_t                        buf_ready_o,
  // Registered output port
  output logic                                         valid_o,
  input  logic                                         ready_i,
  output floo_pkg::floo_flit_t                         flit_o
);

  // Winning route and its group
  floo_pkg::route_idx_t  sel_idx;
  floo_pkg::route_mask_t sel_mask;
  floo_pkg::floo_flit_t  sel_flit;
  logic                  any_ready;

  // Candidate results built side by side
  floo_pkg::floo_flit_t  fwd_flit;
  floo_pkg::floo_flit_t  lsb_flit;
  floo_pkg::floo_flit_t  collect_flit;
  floo_pkg::floo_flit_t  result_flit;
  logic                  lsb;
  logic                  err_found;

  // Output stage
  logic                  valid_q;
  floo_pkg::floo_flit_t  flit_q;
  logic                  out_load;

  // ----------------------------------------
  // Route selection
  // ----------------------------------------

  // Lowest ready route wins as the downward scan writes it last
  always_comb begin
    sel_idx = '0;
    for (int i = `FLOO_NUM_ROUTES - 1; i >= 0; i--) begin
      if (sync_valid_i[i]) begin
        sel_idx = floo_pkg::route_idx_t'(i);
      end
    end
  end

  assign any_ready = |sync_valid_i;
  assign sel_mask  = sync_mask_i[sel_idx];
  assign sel_flit  = buf_flit_i[sel_idx];

  // ----------------------------------------
  // Reduction operations
  // ----------------------------------------

  // SelectAW passes the winner through
  assign fwd_flit = sel_flit;

  // AND of data bit 0 over the group through the W view
  always_comb begin
    lsb = 1'b1;
    for (int i = 0; i < `FLOO_NUM_ROUTES; i++) begin
      if (sel_mask[i]) begin
        lsb &= buf_flit_i[i].payload.w.data[0];
      end
    end
    lsb_flit = sel_flit;
    lsb_flit.payload.w.data[0] = lsb;
  end

  // First slave error in route order through the B view
  always_comb begin
    collect_flit = sel_flit;
    err_found    = 1'b0;
    for (int i = 0; i < `FLOO_NUM_ROUTES; i++) begin
      if (sel_mask[i] && !err_found &&
          (buf_flit_i[i].payload.b.resp == `FLOO_RESP_SLVERR)) begin
        collect_flit = buf_flit_i[i];
        err_found    = 1'b1;
      end
    end
  end

  // Operation of the winner picks the result
  always_comb begin
    case (sel_flit.hdr.collective_op)
      floo_pkg::SelectAW: result_flit = fwd_flit;
      floo_pkg::LsbAnd:   result_flit = lsb_flit;
      floo_pkg::CollectB: result_flit = collect_flit;
      // Reserved code goes out untouched and is flagged below
      default:            result_flit = fwd_flit;
    endcase
  end

  // ----------------------------------------
  // Output stage and release
  // ----------------------------------------

  // Loads when empty or drained this cycle
  assign out_load = !valid_q || ready_i;

  // All participants leave their slots together
  assign buf_ready_o = (out_load && any_ready) ? sel_mask : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (out_load) begin
      valid_q <= any_ready;
    end
  end

  // Merged flit of the group being loaded
  always_ff @(posedge clk_i) begin
    if (out_load && any_ready) begin
      flit_q <= result_flit;
    end
  end

  assign valid_o = valid_q;
  assign flit_o  = flit_q;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Released slots belong to the group named in the winning header
  a_release_in_mask: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (buf_ready_o != '0) |-> ((buf_ready_o & ~sel_flit.hdr.mask) == '0)
  ) else $error("release outside selected group");

  // Held output under back-pressure
  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(flit_o)
  ) else $error("output flit changed while stalled");

  // Reserved operation never leaves the stage
  a_no_reserved_op: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> flit_o.hdr.collective_op != floo_pkg::ReservedOp
  ) else $error("reserved operation on output");

endmodule

// File: floo_reduction_sync.sv
`timescale 1ns/1ps

`include "floo_config.svh"

module floo_reduction_sync (
  // Route this instance checks
  input  floo_pkg::route_idx_t                         sel_i,
  // Buffered flits of all routes
  input  floo_pkg::route_mask_t                        buf_valid_i,
  input  floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0]  buf_flit_i,
  // Group of this route is complete
  output logic                                         sync_valid_o,
  output floo_pkg::route_mask_t                        sync_mask_o
);

  // Flit sitting in our own slot
  floo_pkg::floo_flit_t  own_flit;
  floo_pkg::route_mask_t own_mask;
  logic                  own_valid;

  // Per route match result
  floo_pkg::route_mask_t part_ok;

  assign own_flit  = buf_flit_i[sel_i];
  assign own_mask  = own_flit.hdr.mask;
  assign own_valid = buf_valid_i[sel_i];

  // ----------------------------------------
  // Participant check
  // ----------------------------------------

  // Routes outside the mask never block the group
  always_comb begin
    part_ok = '1;
    for (int i = 0; i < `FLOO_NUM_ROUTES; i++) begin
      if (own_mask[i]) begin
        // Same group means same tag and same operation
        part_ok[i] = buf_valid_i[i]
                  && (buf_flit_i[i].hdr.tag == own_flit.hdr.tag)
                  && (buf_flit_i[i].hdr.collective_op == own_flit.hdr.collective_op);
      end
    end
  end

  // Own slot must hold a flit and every participant must match
  assign sync_valid_o = own_valid && (&part_ok);

  // Mask decides which slots get released later on
  assign sync_mask_o  = own_mask;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A route always takes part in its own group
  always_comb begin
    if (own_valid) begin
      a_self_in_mask: assert final (own_mask[sel_i])
        else $error("route %0d flit does not list itself", sel_i);
    end
  end

endmodule

// File: floo_ingress_buffer.sv
`timescale 1ns/1ps

`include "floo_config.svh"

module floo_ingress_buffer (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  // Input routes
  input  floo_pkg::route_mask_t                        valid_i,
  output floo_pkg::route_mask_t                        ready_o,
  input  floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0]  flit_i,
  // Buffered flits towards the reduction logic
  output floo_pkg::route_mask_t                        buf_valid_o,
  output floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0]  buf_flit_o,
  input  floo_pkg::route_mask_t                        buf_ready_i
);

  // One slot per route
  floo_pkg::route_mask_t                       full_q;
  floo_pkg::floo_flit_t [`FLOO_NUM_ROUTES-1:0] flit_q;

  // Input transfers this cycle
  floo_pkg::route_mask_t                       in_xfer;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // Slot can take a flit when empty or drained in the same cycle
  assign ready_o = ~full_q | buf_ready_i;
  assign in_xfer = valid_i & ready_o;

  // Occupancy, drain first and refill wins
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= '0;
    end else begin
      full_q <= (full_q & ~buf_ready_i) | in_xfer;
    end
  end

  // Payload slots, only written on a transfer
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `FLOO_NUM_ROUTES; i++) begin
      if (in_xfer[i]) begin
        flit_q[i] <= flit_i[i];
      end
    end
  end

  assign buf_valid_o = full_q;
  assign buf_flit_o  = flit_q;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  for (genvar r = 0; r < `FLOO_NUM_ROUTES; r++) begin : gen_slot_check
    // A waiting flit must not change under the reduction logic
    a_slot_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      full_q[r] && !buf_ready_i[r] |=> full_q[r] && $stable(flit_q[r])
    ) else $error("ingress slot %0d changed before drain", r);

    // Arbiter only releases slots that hold a flit
    a_release_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      buf_ready_i[r] |-> full_q[r]
    ) else $error("ingress slot %0d released while empty", r);
  end

endmodule

// File: floo_pkg.sv
`include "floo_config.svh"

package floo_pkg;

  // ----------------------------------------
  // Collective operations
  // ----------------------------------------

  // Two bit code carried in every flit header
  typedef enum logic [1:0] {
    SelectAW   = 2'd0,
    LsbAnd     = 2'd1,
    CollectB   = 2'd2,
    // Never issued, caught at the output
    ReservedOp = 2'd3
  } collect_op_e;

  // One bit per input route
  typedef logic [`FLOO_NUM_ROUTES-1:0] route_mask_t;

  // Index of a single input route
  typedef logic [`FLOO_ROUTE_IDX_WIDTH-1:0] route_idx_t;

  // ----------------------------------------
  // Flit layout
  // ----------------------------------------

  // Header, 10 bits with the default sizing
  typedef struct packed {
    collect_op_e                collective_op;
    // Routes that must each deliver one flit
    route_mask_t                mask;
    logic [`FLOO_TAG_WIDTH-1:0] tag;
  } floo_hdr_t;

  // W view of the payload
  typedef struct packed {
    logic [`FLOO_DATA_WIDTH-1:0] data;
    logic [`FLOO_STRB_WIDTH-1:0] strb;
  } floo_w_payload_t;

  // B view, padded up to the W width
  typedef struct packed {
    logic [1:0]                                   resp;
    logic [3:0]                                   id;
    logic [`FLOO_DATA_WIDTH+`FLOO_STRB_WIDTH-7:0] pad;
  } floo_b_payload_t;

  // Same word, read as W for LsbAnd and as B for CollectB
  typedef union packed {
    floo_w_payload_t w;
    floo_b_payload_t b;
  } floo_payload_u;

  // Full flit as it travels on a route
  typedef struct packed {
    floo_hdr_t     hdr;
    floo_payload_u payload;
  } floo_flit_t;

endpackage

// File: floo_config.svh
`ifndef FLOO_CONFIG_SVH
`define FLOO_CONFIG_SVH

// ----------------------------------------
// Reduction stage sizing
// ----------------------------------------

// Input routes feeding the output port
`define FLOO_NUM_ROUTES 4

// Bits needed to index one route
`define FLOO_ROUTE_IDX_WIDTH $clog2(`FLOO_NUM_ROUTES)

// Write data width of the W view
`define FLOO_DATA_WIDTH 32

// One strobe bit per data byte
`define FLOO_STRB_WIDTH (`FLOO_DATA_WIDTH / 8)

// Tag that ties the flits of one reduction group together
`define FLOO_TAG_WIDTH 4

// B response code for a slave error
`define FLOO_RESP_SLVERR 2'd2

`endif
